// File: Makefile
# Verilator build and run for the 16-point FFT pipeline

VERILATOR   ?= verilator
TOP         ?= fft16_tb
RTL_TOP     ?= fft16_top
FILELIST    ?= compile.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_TEXT   ?= No errors
EXTRA_FLAGS ?=

VFLAGS = --binary --timing -j 0 --Mdir $(BUILD_DIR) --top-module $(TOP) $(EXTRA_FLAGS)

SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) \
		verilog/fft16_pkg.sv verilog/fft16_butterfly.sv verilog/fft16_dif_stage.sv \
		verilog/fft16_output_reorder.sv verilog/fft16_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
verilog/fft16_pkg.sv
verilog/fft16_butterfly.sv
verilog/fft16_dif_stage.sv
verilog/fft16_output_reorder.sv
verilog/fft16_top.sv
tb/fft16_tb.sv

// File: tb/fft16_stim.txt
// per frame three lines: samples 0..15, then re im of bins 0..7, then re im of bins 8..15
// all values are 16-bit two's complement hex
0100 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0100 0000 0100 0000 0100 0000 0100 0000 0100 0000 0100 0000 0100 0000 0100 0000
0100 0000 0100 0000 0100 0000 0100 0000 0100 0000 0100 0000 0100 0000 0100 0000
FED4 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
FED4 0000 FED4 0000 FED4 0000 FED4 0000 FED4 0000 FED4 0000 FED4 0000 FED4 0000
FED4 0000 FED4 0000 FED4 0000 FED4 0000 FED4 0000 FED4 0000 FED4 0000 FED4 0000
0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010
0100 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
FFFB FFFB FFFB FFFB FFFB FFFB FFFB FFFB FFFB FFFB FFFB FFFB FFFB FFFB FFFB FFFB
FFB0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 03E8 0000 0000 0000 0000 0000 0000 0000
03E8 0000 FC18 0000 03E8 0000 FC18 0000 03E8 0000 FC18 0000 03E8 0000 FC18 0000
03E8 0000 FC18 0000 03E8 0000 FC18 0000 03E8 0000 FC18 0000 03E8 0000 FC18 0000
0000 0000 0000 0000 0200 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0200 0000 0000 FE00 FE00 0000 0000 0200 0200 0000 0000 FE00 FE00 0000 0000 0200
0200 0000 0000 FE00 FE00 0000 0000 0200 0200 0000 0000 FE00 FE00 0000 0000 0200
0064 0000 0000 0000 0014 0000 0000 0000 FFE2 0000 0000 0000 0007 0000 0000 0000
0061 0000 0082 FFF3 002B 0000 0082 000D 0061 0000 0082 FFF3 002B 0000 0082 000D
0061 0000 0082 FFF3 002B 0000 0082 000D 0061 0000 0082 FFF3 002B 0000 0082 000D
FC18 0000 0000 0000 01F4 0000 0000 0000 00FA 0000 0000 0000 F830 0000 0000 0000
F736 0000 FB1E F63C 02EE 0000 FB1E 09C4 F736 0000 FB1E F63C 02EE 0000 FB1E 09C4
F736 0000 FB1E F63C 02EE 0000 FB1E 09C4 F736 0000 FB1E F63C 02EE 0000 FB1E 09C4
0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900 0900
9000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000

// File: tb/fft16_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fft16_tb;

    localparam int n_frames        = 9;
    localparam int words_per_frame = 48;        // 16 samples then 16 re/im pairs
    localparam int latency         = 5;
    localparam int watchdog_cycles = n_frames * 4 + 50;

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    fft16_pkg::sample_frame_t in_frame;
    logic                     out_valid;
    fft16_pkg::bin_frame_t    out_bins;

    logic [15:0] stim_mem [0:n_frames*words_per_frame-1];

    string test_name [0:n_frames-1] = '{
        "impulse_pos", "impulse_neg", "dc_small", "dc_neg", "impulse_mid",
        "impulse_quarter", "mixed_a", "mixed_b", "dc_wrap"
    };

    fft16_pkg::bin_frame_t exp_q [$];
    int                    idx_q [$];
    int                    due_q [$];

    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr_state = 32'hae14_114b;

    fft16_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_frame  (in_frame),
        .out_valid (out_valid),
        .out_bins  (out_bins)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic expect_idle(input string what);
        checks++;
        assert (out_valid === 1'b0) else begin
            errors++;
            $display("out_valid went high %s at cycle %0d", what, cycle);
        end
    endtask

    task automatic bins_cleared();
        fft16_pkg::bin_frame_t zero;
        zero = '0;
        checks++;
        assert (out_bins === zero) else begin
            errors++;
            $display("FAILED reset out_bins: expected %h, actual %h", zero, out_bins);
        end
    endtask

    task automatic drive_frame(input int idx);
        fft16_pkg::bin_frame_t exp;
        int base;
        base = idx * words_per_frame;
        for (int i = 0; i < fft16_pkg::n_points; i++) begin
            in_frame[i] = stim_mem[base + i];
            exp[i].re   = stim_mem[base + 16 + 2*i];
            exp[i].im   = stim_mem[base + 17 + 2*i];
        end
        in_valid = 1'b1;
        exp_q.push_back(exp);
        idx_q.push_back(idx);
        due_q.push_back(cycle + latency);       // seen latency negedges later
    endtask

    task automatic check_output();
        fft16_pkg::bin_frame_t exp;
        int idx;
        int due;
        if (out_valid !== 1'b1) begin
            return;
        end
        checks++;
        assert (exp_q.size() > 0) else begin
            errors++;
            $display("out_valid high at cycle %0d with no frame in flight", cycle);
        end
        if (exp_q.size() == 0) begin
            return;
        end
        exp = exp_q.pop_front();
        idx = idx_q.pop_front();
        due = due_q.pop_front();
        checks++;
        assert (cycle == due) else begin
            errors++;
            $display("FAILED %s latency: expected cycle %0d, actual cycle %0d",
                     test_name[idx], due, cycle);
        end
        for (int n = 0; n < fft16_pkg::n_points; n++) begin
            checks += 2;
            assert (out_bins[n].re === exp[n].re) else begin
                errors++;
                $display("FAILED %s bin %0d re: expected %h, actual %h",
                         test_name[idx], n, exp[n].re, out_bins[n].re);
            end
            assert (out_bins[n].im === exp[n].im) else begin
                errors++;
                $display("FAILED %s bin %0d im: expected %h, actual %h",
                         test_name[idx], n, exp[n].im, out_bins[n].im);
            end
        end
    endtask

    initial begin
        int next_frame;
        int gap;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_frame = '0;
        next_frame = 0;
        gap = 0;
        $readmemh("tb/fft16_stim.txt", stim_mem);

        repeat (10) begin
            @(negedge clk);
            expect_idle("during reset");
            bins_cleared();
        end
        rst_n = 1'b1;
        repeat (5) begin
            @(negedge clk);
            expect_idle("before any frame");
            bins_cleared();
        end

        while (next_frame < n_frames || exp_q.size() > 0) begin
            @(negedge clk);
            check_output();
            if (gap > 0) begin
                in_valid = 1'b0;
                gap--;
            end else if (next_frame < n_frames) begin
                drive_frame(next_frame);
                next_frame++;
                draw_bits(2, gap);                  // idle gap of 0..3 cycles
            end else begin
                in_valid = 1'b0;
            end
        end

        repeat (8) begin
            @(negedge clk);
            expect_idle("after the last frame");
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, frames still in flight %0d", watchdog_cycles,
                 exp_q.size());
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/fft16_butterfly.sv
`timescale 1ns/100ps
`default_nettype none

module fft16_butterfly (
    input  fft16_pkg::cplx_t a,
    input  fft16_pkg::cplx_t b,
    input  fft16_pkg::cplx_t w,
    output fft16_pkg::cplx_t sum,
    output fft16_pkg::cplx_t diff
);

    logic signed [2*fft16_pkg::data_w-1:0] diff_re;
    logic signed [2*fft16_pkg::data_w-1:0] diff_im;
    logic signed [2*fft16_pkg::data_w-1:0] prod_re;
    logic signed [2*fft16_pkg::data_w-1:0] prod_im;

    // upper leg wraps at data_w
    assign sum.re = a.re + b.re;
    assign sum.im = a.im + b.im;

    // lower leg is formed at full width before the multiply
    assign diff_re = (2 * fft16_pkg::data_w)'(a.re) - (2 * fft16_pkg::data_w)'(b.re);
    assign diff_im = (2 * fft16_pkg::data_w)'(a.im) - (2 * fft16_pkg::data_w)'(b.im);

    // (dr + j*di) * (wr + j*wi)
    assign prod_re = diff_re * w.re - diff_im * w.im;
    assign prod_im = diff_re * w.im + diff_im * w.re;

    // >>> tw_frac then keep data_w bits [47:16]
    assign diff.re = prod_re[fft16_pkg::tw_frac +: fft16_pkg::data_w];
    assign diff.im = prod_im[fft16_pkg::tw_frac +: fft16_pkg::data_w];

endmodule

`default_nettype wire

// File: verilog/fft16_dif_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fft16_dif_stage #(
    parameter int stage = 0                     // 0 .. n_stages-1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  fft16_pkg::frame_t in_frame,
    output logic              out_valid,
    output fft16_pkg::frame_t out_frame
);

    fft16_pkg::frame_t stage_result;

    // distance between the two legs of a butterfly
    function automatic int half_span();
        return (fft16_pkg::n_points / 2) >> stage;
    endfunction

    // k-th butterfly, upper leg: insert a 0 at the half-span bit
    function automatic int lo_index(input int k);
        int half;
        half = half_span();
        return (k / half) * 2 * half + (k % half);
    endfunction

    function automatic int tw_index(input int k);
        int half;
        half = half_span();
        return (k % half) << stage;
    endfunction

    for (genvar k = 0; k < fft16_pkg::n_points / 2; k++) begin : g_bfly
        fft16_butterfly u_bfly (
            .a    (in_frame[lo_index(k)]),
            .b    (in_frame[lo_index(k) + half_span()]),
            .w    (fft16_pkg::twiddle[tw_index(k)]),
            .sum  (stage_result[lo_index(k)]),
            .diff (stage_result[lo_index(k) + half_span()])
        );
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_frame <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                out_frame <= stage_result;      // hold between frames
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/fft16_output_reorder.sv
`timescale 1ns/100ps
`default_nettype none

module fft16_output_reorder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  fft16_pkg::frame_t     in_frame,
    output logic                  out_valid,
    output fft16_pkg::bin_frame_t out_bins
);

    fft16_pkg::bin_frame_t bins_next;

    // DIF leaves bins in bit-reversed order
    always_comb begin
        logic [fft16_pkg::n_stages-1:0] src;
        for (int n = 0; n < fft16_pkg::n_points; n++) begin
            src = fft16_pkg::bit_reverse(n[fft16_pkg::n_stages-1:0]);
            // drop 8 fraction bits and the top 8 bits
            bins_next[n].re = in_frame[src].re[fft16_pkg::frac_in +: fft16_pkg::sample_w];
            bins_next[n].im = in_frame[src].im[fft16_pkg::frac_in +: fft16_pkg::sample_w];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_bins  <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                out_bins <= bins_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/fft16_pkg.sv
`default_nettype none

package fft16_pkg;

    localparam int n_points = 16;
    localparam int n_stages = 4;                // log2(n_points)
    localparam int sample_w = 16;
    localparam int data_w   = 32;               // 8 fraction bits
    localparam int frac_in  = 8;
    localparam int tw_frac  = 16;               // twiddles are Q16

    typedef logic signed [sample_w-1:0] sample_t;

    // internal complex value
    typedef struct packed {
        logic signed [data_w-1:0] re;
        logic signed [data_w-1:0] im;
    } cplx_t;

    typedef cplx_t [n_points-1:0] frame_t;

    typedef sample_t [n_points-1:0] sample_frame_t;

    // one output bin
    typedef struct packed {
        sample_t re;
        sample_t im;
    } bin_t;

    typedef bin_t [n_points-1:0] bin_frame_t;

    // W16^k = cos(2*pi*k/16) - j*sin(2*pi*k/16), scaled by 2^16
    localparam cplx_t twiddle [0:n_points/2-1] = '{
        '{re: 32'sh0001_0000, im: 32'sh0000_0000},
        '{re: 32'sh0000_EC83, im: 32'shFFFF_9E09},
        '{re: 32'sh0000_B504, im: 32'shFFFF_4AFC},
        '{re: 32'sh0000_61F7, im: 32'shFFFF_137D},
        '{re: 32'sh0000_0000, im: 32'shFFFF_0000},   // -j
        '{re: 32'shFFFF_9E09, im: 32'shFFFF_137D},
        '{re: 32'shFFFF_4AFC, im: 32'shFFFF_4AFC},
        '{re: 32'shFFFF_137D, im: 32'shFFFF_9E09}
    };

    // real sample to internal fixed point, imaginary part is zero
    function automatic cplx_t widen(input sample_t s);
        cplx_t c;
        c.re = data_w'(s) <<< frac_in;          // sign extend, then scale
        c.im = '0;
        return c;
    endfunction

    function automatic logic [n_stages-1:0] bit_reverse(input logic [n_stages-1:0] idx);
        logic [n_stages-1:0] rev;
        for (int k = 0; k < n_stages; k++) begin
            rev[k] = idx[n_stages-1-k];
        end
        return rev;
    endfunction

endpackage

`default_nettype wire

// File: verilog/fft16_top.sv
`timescale 1ns/100ps
`default_nettype none

module fft16_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  fft16_pkg::sample_frame_t in_frame,
    output logic                     out_valid,
    output fft16_pkg::bin_frame_t    out_bins
);

    // entry 0 is the widened input, entry s+1 is the output of stage s
    logic              stage_valid [0:fft16_pkg::n_stages];
    fft16_pkg::frame_t stage_frame [0:fft16_pkg::n_stages];

    assign stage_valid[0] = in_valid;

    for (genvar i = 0; i < fft16_pkg::n_points; i++) begin : g_widen
        assign stage_frame[0][i] = fft16_pkg::widen(in_frame[i]);
    end

    for (genvar s = 0; s < fft16_pkg::n_stages; s++) begin : g_stage
        fft16_dif_stage #(
            .stage (s)
        ) u_stage (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (stage_valid[s]),
            .in_frame  (stage_frame[s]),
            .out_valid (stage_valid[s+1]),
            .out_frame (stage_frame[s+1])
        );
    end

    // 5th register level
    fft16_output_reorder u_reorder (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (stage_valid[fft16_pkg::n_stages]),
        .in_frame  (stage_frame[fft16_pkg::n_stages]),
        .out_valid (out_valid),
        .out_bins  (out_bins)
    );

endmodule

`default_nettype wire
